// File: vlog.f
logic/axis_buf_pkg.sv
logic/fifo_ram.sv
logic/sync_fifo.sv
logic/axis_fifo_wrap.sv
logic/axis_pkt_gate.sv
logic/axis_pkt_buffer.sv
testbench/axis_pkt_buffer_props.sv
testbench/axis_pkt_buffer_tb.sv

// File: testbench/axis_pkt_buffer_tb.sv
// ======================================================================
// Testbench for the AXI-Stream packet buffer. Random packets and
// back-pressure, one oversize packet, scoreboard and bound checks.
// ======================================================================

`timescale 1ns/1ps

module axis_pkt_buffer_tb
    import axis_buf_pkg::*;
();

    localparam int          NUM_SMALL   = 30;
    localparam int          BIG_LEN     = 24;
    localparam int          BIG_AT      = 12;  // packet index of the oversize one.
    localparam int          HOLD_CYCLES = 40;
    localparam logic [15:0] SEED        = 16'd13;

    logic                 clk_i;
    logic                 reset_i;
    logic                 s_valid_i;
    axis_beat_t           s_beat_i;
    logic                 s_ready_o;
    logic                 m_valid_o;
    axis_beat_t           m_beat_o;
    logic                 m_ready_i;
    logic                 a_full_o;
    logic                 a_empty_o;
    logic [CNT_WIDTH-1:0] data_cnt_o;

    logic [15:0] lfsr = SEED;
    axis_beat_t  beats[$];   // every beat in send order.
    axis_beat_t  exp_q[$];
    int          big_first   = 0;
    int          pkt_pend    = 0;
    int          out_cnt     = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 0;

    axis_pkt_buffer UUT (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .s_valid_i (s_valid_i),
        .s_beat_i  (s_beat_i),
        .s_ready_o (s_ready_o),
        .m_valid_o (m_valid_o),
        .m_beat_o  (m_beat_o),
        .m_ready_i (m_ready_i),
        .a_full_o  (a_full_o),
        .a_empty_o (a_empty_o),
        .data_cnt_o(data_cnt_o)
    );

    bind axis_pkt_buffer axis_pkt_buffer_props u_props (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .s_ready_i     (s_ready_o),
        .m_valid_i     (m_valid_o),
        .m_beat_i      (m_beat_o),
        .m_ready_i     (m_ready_i),
        .a_full_i      (a_full_o),
        .a_empty_i     (a_empty_o),
        .data_cnt_i    (data_cnt_o),
        .pkts_pending_i(axis_pkt_buffer_tb.pkt_pend)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    task automatic fail_stop();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic build_packets();
        int         len;
        axis_beat_t b;
        for (int p = 0; p <= NUM_SMALL; p++) begin
            if (p == BIG_AT) begin
                len       = BIG_LEN;
                big_first = beats.size();
            end else begin
                len = int'(lfsr_bits(3) % 6) + 1;
            end
            for (int k = 0; k < len; k++) begin
                b.tdata = lfsr_bits(DATA_WIDTH);
                b.tlast = (k == len - 1);
                beats.push_back(b);
            end
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever begin
            #50 clk_i = ~clk_i;
        end
    end

    initial begin
        int idx;
        int hold;
        bit hold_used;
        reset_i   = 1'b1;
        s_valid_i = 1'b0;
        s_beat_i  = '0;
        m_ready_i = 1'b0;
        build_packets();
        cycle_limit = beats.size() * 8 + 500;
        repeat (16) @(posedge clk_i);
        reset_i <= 1'b0;
        @(negedge clk_i);
        assert (!m_valid_o) else begin
            $display("Mismatch m_valid_o after reset: got %h, expected 0", m_valid_o);
            fail_stop();
        end
        assert (s_ready_o) else begin
            $display("Mismatch s_ready_o after reset: got %h, expected 1", s_ready_o);
            fail_stop();
        end
        assert (data_cnt_o == '0) else begin
            $display("Mismatch data_cnt_o after reset: got %h, expected 0", data_cnt_o);
            fail_stop();
        end
        assert (a_empty_o) else begin
            $display("Mismatch a_empty_o after reset: got %h, expected 1", a_empty_o);
            fail_stop();
        end

        idx       = 0;
        hold      = 0;
        hold_used = 0;
        while (idx < beats.size()) begin
            @(posedge clk_i);
            if (s_valid_i && s_ready_o) begin
                idx++;
            end
            // stall the sink once the oversize packet starts, so the FIFO fills.
            if (idx == big_first && !hold_used) begin
                hold      = HOLD_CYCLES;
                hold_used = 1;
            end
            if (idx < beats.size() && ((s_valid_i && !s_ready_o) || lfsr_bits(2) != 0)) begin
                s_valid_i <= 1'b1;
                s_beat_i  <= beats[idx];
            end else begin
                s_valid_i <= 1'b0;
            end
            if (hold > 0) begin
                m_ready_i <= 1'b0;
                hold--;
            end else begin
                m_ready_i <= (lfsr_bits(2) != 0);
            end
        end

        while (out_cnt < beats.size()) begin
            @(posedge clk_i);
            m_ready_i <= (lfsr_bits(2) != 0);
        end
        @(negedge clk_i);
        if (exp_q.size() == 0 && pkt_pend == 0 && data_cnt_o == '0 && !m_valid_o &&
            UUT.u_props.fail_cnt == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("end of run wrong: %0d beats queued, count %h, %0d assertion failures",
                     exp_q.size(), data_cnt_o, UUT.u_props.fail_cnt);
            fail_stop();
        end
    end

    // scoreboard and the packet count that the gating check uses.
    always @(posedge clk_i) begin
        axis_beat_t exp;
        int         d;
        if (!reset_i) begin
            d = 0;
            if (s_valid_i && s_ready_o) begin
                exp_q.push_back(s_beat_i);
                d = d + int'(s_beat_i.tlast);
            end
            if (m_valid_o && m_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("output transfer with no accepted beat to match it");
                    fail_stop();
                end else begin
                    exp = exp_q.pop_front();
                    assert (m_beat_o.tdata == exp.tdata) else begin
                        $display("Mismatch m_beat_o.tdata: got %h, expected %h",
                                 m_beat_o.tdata, exp.tdata);
                        fail_stop();
                    end
                    assert (m_beat_o.tlast == exp.tlast) else begin
                        $display("Mismatch m_beat_o.tlast: got %h, expected %h",
                                 m_beat_o.tlast, exp.tlast);
                        fail_stop();
                    end
                    d = d - int'(m_beat_o.tlast);
                    out_cnt <= out_cnt + 1;
                end
            end
            pkt_pend <= pkt_pend + d;
        end
    end

    always @(negedge clk_i) begin
        if (UUT.u_props.fail_cnt != 0) begin
            $display("a protocol assertion failed, see the error above");
            fail_stop();
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: run not finished after %0d cycles", cycle_cnt);
            fail_stop();
        end
    end

endmodule

// File: testbench/axis_pkt_buffer_props.sv
// ======================================================================
// Protocol checks for the packet buffer. Store-and-forward gating,
// back-pressure stability, ready and the fill flags.
// ======================================================================

`timescale 1ns/1ps

module axis_pkt_buffer_props
    import axis_buf_pkg::*;
(
    input logic                 clk_i,
    input logic                 reset_i,
    input logic                 s_ready_i,
    input logic                 m_valid_i,
    input axis_beat_t           m_beat_i,
    input logic                 m_ready_i,
    input logic                 a_full_i,
    input logic                 a_empty_i,
    input logic [CNT_WIDTH-1:0] data_cnt_i,
    input int                   pkts_pending_i  // complete packets not yet drained.
);

    int unsigned fail_cnt = 0;  // read by the testbench top.
    logic        full;

    assign full = (data_cnt_i == CNT_WIDTH'(FIFO_DEPTH));

    // beats only leave once a whole packet is stored, or the FIFO is full.
    gate_holds: assert property (@(posedge clk_i) disable iff (reset_i)
        m_valid_i |-> (pkts_pending_i != 0) || full)
        else begin
            $error("output valid with no complete packet stored and the FIFO not full");
            fail_cnt++;
        end

    stall_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        m_valid_i && !m_ready_i |=> m_valid_i && $stable(m_beat_i))
        else begin
            $error("output beat changed or dropped while stalled");
            fail_cnt++;
        end

    ready_full: assert property (@(posedge clk_i) disable iff (reset_i)
        s_ready_i == !full)
        else begin
            $error("Mismatch s_ready_o: got %h, expected %h for count %h",
                   $sampled(s_ready_i), !$sampled(full), $sampled(data_cnt_i));
            fail_cnt++;
        end

    a_full_ok: assert property (@(posedge clk_i) disable iff (reset_i)
        a_full_i == (data_cnt_i >= A_FULL_LEVEL))
        else begin
            $error("Mismatch a_full_o: got %h, expected %h for count %h",
                   $sampled(a_full_i), $sampled(data_cnt_i) >= A_FULL_LEVEL,
                   $sampled(data_cnt_i));
            fail_cnt++;
        end

    a_empty_ok: assert property (@(posedge clk_i) disable iff (reset_i)
        a_empty_i == (data_cnt_i <= A_EMPTY_LEVEL))
        else begin
            $error("Mismatch a_empty_o: got %h, expected %h for count %h",
                   $sampled(a_empty_i), $sampled(data_cnt_i) <= A_EMPTY_LEVEL,
                   $sampled(data_cnt_i));
            fail_cnt++;
        end

    count_range: assert property (@(posedge clk_i) disable iff (reset_i)
        data_cnt_i <= CNT_WIDTH'(FIFO_DEPTH))
        else begin
            $error("fill count %h above the FIFO depth", $sampled(data_cnt_i));
            fail_cnt++;
        end

endmodule

// File: logic/axis_pkt_buffer.sv
// ======================================================================
// AXI-Stream packet buffer top. FIFO wrapper followed by the packet
// gate, single clock.
// ======================================================================

`timescale 1ns/1ps

module axis_pkt_buffer
    import axis_buf_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_i,

    input  logic                 s_valid_i,
    input  axis_beat_t           s_beat_i,
    output logic                 s_ready_o,

    output logic                 m_valid_o,
    output axis_beat_t           m_beat_o,
    input  logic                 m_ready_i,

    output logic                 a_full_o,
    output logic                 a_empty_o,
    output logic [CNT_WIDTH-1:0] data_cnt_o
);

    logic       fifo_valid;
    axis_beat_t fifo_beat;
    logic       fifo_ready;
    logic       push_last;
    logic       fifo_full;

    axis_fifo_wrap i_axis_fifo_wrap (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .s_valid_i   (s_valid_i),
        .s_beat_i    (s_beat_i),
        .s_ready_o   (s_ready_o),
        .fifo_valid_o(fifo_valid),
        .fifo_beat_o (fifo_beat),
        .fifo_ready_i(fifo_ready),
        .push_last_o (push_last),
        .full_o      (fifo_full),
        .a_full_o    (a_full_o),
        .a_empty_o   (a_empty_o),
        .data_cnt_o  (data_cnt_o)
    );

    axis_pkt_gate i_axis_pkt_gate (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .push_last_i(push_last),
        .fifo_full_i(fifo_full),
        .in_valid_i (fifo_valid),
        .in_beat_i  (fifo_beat),
        .in_ready_o (fifo_ready),
        .m_valid_o  (m_valid_o),
        .m_beat_o   (m_beat_o),
        .m_ready_i  (m_ready_i)
    );

endmodule

// File: logic/axis_pkt_gate.sv
// ======================================================================
// Store-and-forward gate. Lets beats out only while a complete packet
// sits in the buffer, or when the FIFO is full.
// ======================================================================

`timescale 1ns/1ps

module axis_pkt_gate
    import axis_buf_pkg::*;
(
    input  logic       clk_i,
    input  logic       reset_i,

    input  logic       push_last_i,
    input  logic       fifo_full_i,

    input  logic       in_valid_i,
    input  axis_beat_t in_beat_i,
    output logic       in_ready_o,

    output logic       m_valid_o,
    output axis_beat_t m_beat_o,
    input  logic       m_ready_i
);

    // up to FIFO_DEPTH single-beat packets can be stored at once.
    logic [CNT_WIDTH-1:0] pkt_cnt;
    logic                 pop_last;
    logic                 release_en;

    // a tlast beat leaves through the master port.
    assign pop_last = in_valid_i & in_ready_o & in_beat_i.tlast;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pkt_cnt <= '0;
        end else begin
            case ({push_last_i, pop_last})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;  // none or both.
            endcase
        end
    end

    // A full FIFO opens the gate too. Otherwise a packet longer than the
    // FIFO could never complete and the buffer would lock up.
    assign release_en = (pkt_cnt != '0) | fifo_full_i;

    assign m_valid_o  = in_valid_i & release_en;
    assign in_ready_o = m_ready_i & release_en;
    assign m_beat_o   = in_beat_i;

endmodule

// File: logic/axis_fifo_wrap.sv
// ======================================================================
// Stream wrapper around the sync FIFO. Turns valid/ready handshakes
// into push and pop and stores whole beats as FIFO words.
// ======================================================================

`timescale 1ns/1ps

module axis_fifo_wrap
    import axis_buf_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_i,

    input  logic                 s_valid_i,
    input  axis_beat_t           s_beat_i,
    output logic                 s_ready_o,

    output logic                 fifo_valid_o,
    output axis_beat_t           fifo_beat_o,
    input  logic                 fifo_ready_i,

    output logic                 push_last_o,
    output logic                 full_o,
    output logic                 a_full_o,
    output logic                 a_empty_o,
    output logic [CNT_WIDTH-1:0] data_cnt_o
);

    beat_word_t wr_word;
    beat_word_t rd_word;
    logic       push;
    logic       pop;
    logic       empty;
    logic       full;

    assign wr_word = s_beat_i;  // tlast travels with tdata.

    assign s_ready_o    = ~full;
    assign fifo_valid_o = ~empty;
    assign fifo_beat_o  = rd_word;

    assign push = s_valid_i & ~full;
    assign pop  = fifo_valid_o & fifo_ready_i;

    // end of a packet went into the FIFO this cycle.
    assign push_last_o = push & s_beat_i.tlast;
    assign full_o      = full;

    sync_fifo i_sync_fifo (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .data_i    (wr_word),
        .push_i    (push),
        .pop_i     (pop),
        .data_o    (rd_word),
        .empty_o   (empty),
        .full_o    (full),
        .a_empty_o (a_empty_o),
        .a_full_o  (a_full_o),
        .data_cnt_o(data_cnt_o)
    );

endmodule

// File: logic/sync_fifo.sv
// ======================================================================
// Synchronous first-word-fall-through FIFO. RAM read stage plus an
// output prefetch register, with full, empty, almost flags and count.
// ======================================================================

`timescale 1ns/1ps

module sync_fifo
    import axis_buf_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 reset_i,

    input  beat_word_t           data_i,
    input  logic                 push_i,
    input  logic                 pop_i,

    output beat_word_t           data_o,
    output logic                 empty_o,
    output logic                 full_o,
    output logic                 a_empty_o,
    output logic                 a_full_o,
    output logic [CNT_WIDTH-1:0] data_cnt_o
);

    logic [PTR_WIDTH:0]   wr_ptr;  // top bit is the wrap bit.
    logic [PTR_WIDTH:0]   rd_ptr;
    logic [CNT_WIDTH-1:0] word_cnt;

    logic       push_ok;
    logic       pop_ok;
    logic       ram_empty;
    logic       ram_rd;
    logic       mid_valid;  // ram read register holds a word.
    logic       out_valid;
    logic       load_out;
    beat_word_t ram_rd_data;
    beat_word_t out_word;

    assign push_ok   = push_i & ~full_o;
    assign pop_ok    = pop_i & out_valid;
    assign ram_empty = (wr_ptr == rd_ptr);

    // the output register takes the read word when it is free or leaving.
    assign load_out = mid_valid & (~out_valid | pop_ok);

    // read ahead whenever the read register is free or being emptied.
    assign ram_rd = ~ram_empty & (~mid_valid | load_out);

    fifo_ram i_fifo_ram (
        .clk_i    (clk_i),
        .wr_en_i  (push_ok),
        .wr_addr_i(wr_ptr[PTR_WIDTH-1:0]),
        .wr_data_i(data_i),
        .rd_en_i  (ram_rd),
        .rd_addr_i(rd_ptr[PTR_WIDTH-1:0]),
        .rd_data_o(ram_rd_data)
    );

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (ram_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mid_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (ram_rd) begin
                mid_valid <= 1'b1;
            end else if (load_out) begin
                mid_valid <= 1'b0;
            end

            if (load_out) begin
                out_valid <= 1'b1;
            end else if (pop_ok) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_out) begin
            out_word <= ram_rd_data;
        end
    end

    // Counts every stored word, the two read-side registers included.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            word_cnt <= '0;
        end else begin
            case ({push_ok, pop_ok})
                2'b10:   word_cnt <= word_cnt + 1'b1;
                2'b01:   word_cnt <= word_cnt - 1'b1;
                default: word_cnt <= word_cnt;
            endcase
        end
    end

    assign data_o     = out_word;
    assign empty_o    = ~out_valid;
    assign full_o     = (word_cnt == CNT_WIDTH'(FIFO_DEPTH));
    assign a_full_o   = (word_cnt >= A_FULL_LEVEL);
    assign a_empty_o  = (word_cnt <= A_EMPTY_LEVEL);
    assign data_cnt_o = word_cnt;

endmodule

// File: logic/fifo_ram.sv
// ======================================================================
// Simple dual-port memory for the packet buffer FIFO. One write port,
// one read port with a registered output.
// ======================================================================

`timescale 1ns/1ps

module fifo_ram
    import axis_buf_pkg::*;
(
    input  logic                 clk_i,

    input  logic                 wr_en_i,
    input  logic [PTR_WIDTH-1:0] wr_addr_i,
    input  beat_word_t           wr_data_i,

    input  logic                 rd_en_i,
    input  logic [PTR_WIDTH-1:0] rd_addr_i,
    output beat_word_t           rd_data_o
);

    beat_word_t mem [FIFO_DEPTH];

    // write port.
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // the read register only moves on rd_en_i, so a word that has been
    // read but not yet taken stays put.
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

// File: logic/axis_buf_pkg.sv
// ======================================================================
// Shared sizes, thresholds and beat type for the AXI-Stream packet
// buffer.
// ======================================================================

package axis_buf_pkg;

    // stream payload width.
    localparam int DATA_WIDTH = 32;

    // beats held by the whole FIFO, output registers included.
    localparam int FIFO_DEPTH = 16;

    localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

    // one extra bit so a count can reach FIFO_DEPTH.
    localparam int CNT_WIDTH = PTR_WIDTH + 1;

    // almost-full is set at or above this fill count.
    localparam logic [CNT_WIDTH-1:0] A_FULL_LEVEL = CNT_WIDTH'(FIFO_DEPTH - 2);

    // almost-empty is set at or below this fill count.
    localparam logic [CNT_WIDTH-1:0] A_EMPTY_LEVEL = CNT_WIDTH'(2);

    // one stream beat, tlast on top of tdata.
    typedef struct packed {
        logic                  tlast;
        logic [DATA_WIDTH-1:0] tdata;
    } axis_beat_t;

    // a FIFO word is a whole beat.
    typedef axis_beat_t beat_word_t;

endpackage
